// ==== Bender.yml ====
package:
  name: ring_cache_ctrl

sources:
  - files:
      - rtl/ring_cache_pkg.sv
      - rtl/tag_port_if.sv
      - rtl/rc_miss_track_stage.sv
      - rtl/l1d_tag_store.sv
      - rtl/l1i_tag_store.sv
      - rtl/rc_fill_stage.sv
      - rtl/ring_cache_ctrl.sv
  - target: test
    files:
      - bench/rc_checker.sv
      - bench/tb_ring_cache_ctrl.sv

// ==== bench/rc_checker.sv ====
`timescale 1ns/100ps

module rc_checker
	import ring_cache_pkg::*;
	#(parameter core_id_t CORE_ID = '0)
	(input clk,
	input reset,
	input string test_name,

	// DUT inputs, sampled at the same edges as the DUT
	input miss_valid,
	input cache_type_t miss_cache_type,
	input thread_idx_t miss_thread,
	input miss_store,
	input [ADDR_W-1:0] miss_addr,
	input ring_valid,
	input ring_ack,
	input core_id_t ring_dest_core,
	input cache_type_t ring_cache_type,
	input [ADDR_W-1:0] ring_addr,

	// DUT fill report
	input fill_valid,
	input cache_type_t fill_cache_type,
	input thread_idx_t fill_thread,
	input l1d_way_idx_t fill_way,
	input need_writeback,
	input [ADDR_W-1:0] evicted_addr,
	input orphan_ack,

	output int check_count,
	output int error_count);

	typedef struct packed {
		logic fill;
		logic orphan;
		cache_type_t ctype;
		thread_idx_t thread;
		l1d_way_idx_t way;
		logic writeback;
		logic [ADDR_W-1:0] evicted;
	} report_t;

	// Miss table model, first index is the cache type
	logic pend [2][THREADS_PER_CORE];
	logic [LINE_ADDR_W-1:0] pend_line [2][THREADS_PER_CORE];
	logic pend_store [2][THREADS_PER_CORE];

	// Tag store model, tree bits are {root, left, right}
	l1d_tag_t d_tag [L1D_SETS][L1D_WAYS];
	line_state_t d_state [L1D_SETS][L1D_WAYS];
	logic [2:0] d_tree [L1D_SETS];
	logic [2:0] i_tree [L1I_SETS];

	// Report due after the current edge, and the one due after the next edge
	report_t exp_now;
	report_t exp_next;

	initial
	begin
		check_count = 0;
		error_count = 0;
	end

	// Victim walk of the three-bit tree
	function automatic logic [1:0] tree_victim(input logic [2:0] t);
		if (!t[2])
			return t[1] ? 2'd1 : 2'd0;
		return t[0] ? 2'd3 : 2'd2;
	endfunction

	// Point the tree away from the filled way
	function automatic logic [2:0] tree_touch(input logic [2:0] t, input logic [1:0] way);
		logic [2:0] n;
		case (way)
			2'd0: n = {1'b1, 1'b1, t[0]};
			2'd1: n = {1'b1, 1'b0, t[0]};
			2'd2: n = {1'b0, t[1], 1'b1};
			default: n = {1'b0, t[1], 1'b0};
		endcase
		return n;
	endfunction

	// Expected report for a matched acknowledge
	function automatic report_t ref_fill(input cache_type_t ctype, input thread_idx_t thread,
		input ring_addr_u addr, input l1d_tag_t [3:0] tags, input line_state_t [3:0] states,
		input logic [2:0] dtree, input logic [2:0] itree);
		report_t r;
		logic hit;
		r = '0;
		r.fill = 1'b1;
		r.ctype = ctype;
		r.thread = thread;
		hit = 1'b0;
		// Instruction side never hits and never writes back
		if (ctype == CT_ICACHE)
		begin
			r.way = tree_victim(itree);
			return r;
		end
		// Lowest valid way holding the tag
		for (int w = L1D_WAYS - 1; w >= 0; w--)
		begin
			if (states[w] != INVALID && tags[w] == addr.dcache.tag)
			begin
				hit = 1'b1;
				r.way = 2'(w);
			end
		end
		if (!hit)
		begin
			r.way = tree_victim(dtree);
			r.writeback = states[r.way] == MODIFIED;
			r.evicted = {tags[r.way], addr.dcache.set_idx, {LINE_OFFSET_W{1'b0}}};
		end
		return r;
	endfunction

	// Model step per edge, acknowledge before registration
	always @(posedge clk)
	begin : model_step
		int ct;
		int t_hit;
		logic found;
		ring_addr_u word;
		l1d_set_idx_t dset;
		l1i_set_idx_t iset;
		l1d_tag_t [3:0] set_tags;
		line_state_t [3:0] set_states;
		if (reset)
		begin
			pend = '{default: '0};
			d_tag = '{default: '0};
			d_state = '{default: INVALID};
			d_tree = '{default: '0};
			i_tree = '{default: '0};
			exp_now = '0;
			exp_next = '0;
		end
		else
		begin
			exp_now = exp_next;
			exp_next = '0;
			ct = int'(ring_cache_type);
			word = ring_addr;
			if (ring_valid && ring_ack && ring_dest_core == CORE_ID)
			begin
				found = 1'b0;
				t_hit = 0;
				for (int t = THREADS_PER_CORE - 1; t >= 0; t--)
				begin
					if (pend[ct][t] && pend_line[ct][t] == ring_addr[ADDR_W-1:LINE_OFFSET_W])
					begin
						found = 1'b1;
						t_hit = t;
					end
				end
				if (!found)
					exp_next.orphan = 1'b1;
				else
				begin
					pend[ct][t_hit] = 1'b0;
					dset = word.dcache.set_idx;
					iset = word.icache.set_idx;
					for (int w = 0; w < L1D_WAYS; w++)
					begin
						set_tags[w] = d_tag[dset][w];
						set_states[w] = d_state[dset][w];
					end
					exp_next = ref_fill(ring_cache_type, thread_idx_t'(t_hit), word,
						set_tags, set_states, d_tree[dset], i_tree[iset]);
					// Apply the fill so the next acknowledge sees it
					if (ring_cache_type == CT_ICACHE)
						i_tree[iset] = tree_touch(i_tree[iset], exp_next.way);
					else
					begin
						d_tag[dset][exp_next.way] = word.dcache.tag;
						d_state[dset][exp_next.way] = pend_store[ct][t_hit] ? MODIFIED : SHARED;
						d_tree[dset] = tree_touch(d_tree[dset], exp_next.way);
					end
				end
			end
			// New registration overwrites the entry
			if (miss_valid)
			begin
				pend[int'(miss_cache_type)][miss_thread] = 1'b1;
				pend_line[int'(miss_cache_type)][miss_thread] = miss_addr[ADDR_W-1:LINE_OFFSET_W];
				pend_store[int'(miss_cache_type)][miss_thread] = miss_store;
			end
		end
	end

	task automatic compare_field(input string field, input logic [ADDR_W-1:0] expected,
		input logic [ADDR_W-1:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("[ERROR] %s: %s expected 'h%0h, actual 'h%0h at %0t", test_name, field,
				expected, actual, $time);
		end
	endtask

	// Outputs are settled mid-cycle
	always @(negedge clk)
	begin
		if (!reset)
		begin
			compare_field("fill_valid", exp_now.fill, fill_valid);
			compare_field("orphan_ack", exp_now.orphan, orphan_ack);
			compare_field("need_writeback", exp_now.writeback, need_writeback);
			if (exp_now.fill)
			begin
				compare_field("fill_cache_type", exp_now.ctype, fill_cache_type);
				compare_field("fill_thread", exp_now.thread, fill_thread);
				compare_field("fill_way", exp_now.way, fill_way);
			end
			// Evicted address only means something with a writeback
			if (exp_now.writeback)
				compare_field("evicted_addr", exp_now.evicted, evicted_addr);
		end
	end

endmodule

// ==== bench/tb_ring_cache_ctrl.sv ====
`timescale 1ns/100ps

module tb_ring_cache_ctrl
	import ring_cache_pkg::*;
	();

	logic clk;
	logic reset;
	logic miss_valid;
	cache_type_t miss_cache_type;
	thread_idx_t miss_thread;
	logic miss_store;
	logic [ADDR_W-1:0] miss_addr;
	logic ring_valid;
	logic ring_ack;
	core_id_t ring_dest_core;
	cache_type_t ring_cache_type;
	logic [ADDR_W-1:0] ring_addr;
	logic fill_valid;
	cache_type_t fill_cache_type;
	thread_idx_t fill_thread;
	l1d_way_idx_t fill_way;
	logic need_writeback;
	logic [ADDR_W-1:0] evicted_addr;
	logic orphan_ack;

	string test_name;
	int check_count;
	int error_count;
	int timeout_count;
	// Last address registered per entry feeds the random acknowledges
	logic [ADDR_W-1:0] last_addr [2][THREADS_PER_CORE];

	ring_cache_ctrl #(.CORE_ID(2'd1)) i_dut (.*);

	rc_checker #(.CORE_ID(2'd1)) i_checker (.*);

	initial
		clk = 1'b0;

	// 8 ns period
	always #4 clk = ~clk;

	function automatic logic [ADDR_W-1:0] data_addr(input int tag, input int set,
		input int offset);
		return {l1d_tag_t'(tag), l1d_set_idx_t'(set), 6'(offset)};
	endfunction

	function automatic logic [ADDR_W-1:0] inst_addr(input int tag, input int set,
		input int offset);
		return {l1i_tag_t'(tag), l1i_set_idx_t'(set), 6'(offset)};
	endfunction

	// All drive tasks start and end 1 ns after a rising edge
	task automatic register_miss(input cache_type_t ct, input int thread, input logic store,
		input logic [ADDR_W-1:0] addr);
		miss_valid = 1'b1;
		miss_cache_type = ct;
		miss_thread = thread_idx_t'(thread);
		miss_store = store;
		miss_addr = addr;
		@(posedge clk);
		#1;
		miss_valid = 1'b0;
	endtask

	task automatic send_ack(input int dest, input cache_type_t ct,
		input logic [ADDR_W-1:0] addr);
		ring_valid = 1'b1;
		ring_ack = 1'b1;
		ring_dest_core = core_id_t'(dest);
		ring_cache_type = ct;
		ring_addr = addr;
		@(posedge clk);
		#1;
		ring_valid = 1'b0;
		ring_ack = 1'b0;
	endtask

	// Wait for a fill or orphan pulse within a bounded number of cycles
	task automatic wait_report();
		int cycles;
		cycles = 0;
		@(posedge clk);
		#1;
		while (!(fill_valid || orphan_ack) && cycles < 10)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!(fill_valid || orphan_ack))
		begin
			timeout_count++;
			$display("Timeout in %s: no fill report or orphan flag within 10 cycles",
				test_name);
		end
	endtask

	initial
	begin : stimulus
		cache_type_t ct;
		int th;
		timeout_count = 0;
		test_name = "reset";
		last_addr = '{default: '0};
		reset = 1'b1;
		miss_valid = 1'b0;
		miss_cache_type = CT_DCACHE;
		miss_thread = '0;
		miss_store = 1'b0;
		miss_addr = '0;
		ring_valid = 1'b0;
		ring_ack = 1'b0;
		ring_dest_core = '0;
		ring_cache_type = CT_DCACHE;
		ring_addr = '0;
		void'($urandom(32'h1c10));
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		// Set 5 fills ways 0, 2, 1 and 3 in order
		// The store into way 0 leaves it dirty for the eviction
		test_name = "data_fill_order";
		register_miss(CT_DCACHE, 0, 1'b1, data_addr('h100, 5, 0));
		register_miss(CT_DCACHE, 1, 1'b0, data_addr('h101, 5, 8));
		register_miss(CT_DCACHE, 2, 1'b1, data_addr('h102, 5, 16));
		register_miss(CT_DCACHE, 3, 1'b0, data_addr('h103, 5, 24));
		for (int t = 0; t < 4; t++)
		begin
			// Offset differs from the miss because only the line address matters
			send_ack(1, CT_DCACHE, data_addr('h100 + t, 5, 40));
			wait_report();
		end

		// Fifth line pushes out the dirty way 0
		test_name = "data_evict";
		register_miss(CT_DCACHE, 0, 1'b0, data_addr('h104, 5, 0));
		send_ack(1, CT_DCACHE, data_addr('h104, 5, 0));
		wait_report();
		test_name = "data_refill_hit";
		register_miss(CT_DCACHE, 1, 1'b1, data_addr('h102, 5, 4));
		send_ack(1, CT_DCACHE, data_addr('h102, 5, 0));
		wait_report();

		// Instruction fills reuse set number 5
		test_name = "inst_fill";
		for (int t = 0; t < 3; t++)
			register_miss(CT_ICACHE, t, 1'b0, inst_addr('h100 + t, 5, 0));
		for (int t = 0; t < 3; t++)
		begin
			send_ack(1, CT_ICACHE, inst_addr('h100 + t, 5, 12));
			wait_report();
		end
		// A hit on way 0 shows that data set 5 kept its lines
		register_miss(CT_DCACHE, 2, 1'b0, data_addr('h104, 5, 0));
		send_ack(1, CT_DCACHE, data_addr('h104, 5, 0));
		wait_report();

		// Another core's acknowledge leaves the entry pending
		test_name = "orphan_other_core";
		register_miss(CT_DCACHE, 3, 1'b0, data_addr('h200, 7, 0));
		send_ack(2, CT_DCACHE, data_addr('h200, 7, 0));
		repeat (3) @(posedge clk);
		#1;
		test_name = "orphan_no_pending";
		send_ack(1, CT_DCACHE, data_addr('h3ff, 5, 0));
		wait_report();
		test_name = "orphan_repeat";
		send_ack(1, CT_DCACHE, data_addr('h200, 7, 0));
		wait_report();
		send_ack(1, CT_DCACHE, data_addr('h200, 7, 0));
		wait_report();

		// Consecutive acknowledges to set 9 rely on forwarding
		test_name = "back_to_back";
		for (int t = 0; t < 4; t++)
			register_miss(CT_DCACHE, t, t[0], data_addr('h300 + t, 9, 0));
		send_ack(1, CT_DCACHE, data_addr('h300, 9, 0));
		send_ack(1, CT_DCACHE, data_addr('h301, 9, 0));
		wait_report();
		send_ack(1, CT_DCACHE, data_addr('h302, 9, 0));
		send_ack(1, CT_DCACHE, data_addr('h303, 9, 0));
		wait_report();

		// Small tag and set pool keeps hits, evictions and orphans frequent
		test_name = "random_traffic";
		for (int n = 0; n < 400; n++)
		begin
			ct = cache_type_t'($urandom_range(1, 0));
			th = $urandom_range(THREADS_PER_CORE - 1, 0);
			miss_valid = $urandom_range(2, 0) == 0;
			miss_cache_type = ct;
			miss_thread = thread_idx_t'(th);
			miss_store = 1'($urandom_range(1, 0));
			if (ct == CT_DCACHE)
				miss_addr = data_addr($urandom_range(5, 0), $urandom_range(1, 0),
					$urandom_range(63, 0));
			else
				miss_addr = inst_addr($urandom_range(5, 0), $urandom_range(1, 0),
					$urandom_range(63, 0));
			if (miss_valid)
				last_addr[int'(ct)][th] = miss_addr;
			ring_valid = 1'($urandom_range(1, 0));
			ring_ack = $urandom_range(3, 0) != 0;
			ring_dest_core = $urandom_range(3, 0) == 0 ? core_id_t'($urandom) : 2'd1;
			ring_cache_type = cache_type_t'($urandom_range(1, 0));
			// Mostly a registered line and sometimes a random one
			if ($urandom_range(3, 0) != 0)
				ring_addr = last_addr[int'(ring_cache_type)][$urandom_range(3, 0)]
					^ 32'($urandom_range(63, 0));
			else
				ring_addr = data_addr($urandom_range(5, 0), $urandom_range(1, 0), 0);
			@(posedge clk);
			#1;
		end
		miss_valid = 1'b0;
		ring_valid = 1'b0;
		ring_ack = 1'b0;
		repeat (4) @(posedge clk);

		$display("Checks: %0d, value errors: %0d, timeouts: %0d", check_count, error_count,
			timeout_count);
		if (error_count == 0 && timeout_count == 0 && check_count > 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== rtl/l1d_tag_store.sv ====
`timescale 1ns/100ps

module l1d_tag_store
	import ring_cache_pkg::*;
	(input clk,
	input reset,
	l1d_tag_port_if.store port);

	l1d_tag_t tags [L1D_SETS][L1D_WAYS];
	line_state_t states [L1D_SETS][L1D_WAYS];
	plru_bits_t lru_bits [L1D_SETS];

	logic update_any;
	logic same_set;
	plru_way_t update_way;
	plru_bits_t lru_next;
	plru_bits_t lru_snoop;

	assign update_any = |port.update_en_oh;
	// Write and snoop hitting one set at one edge
	assign same_set = update_any && port.update_set == port.snoop_set;
	assign update_way = way_from_oh(port.update_en_oh);
	assign lru_next = plru_update(lru_bits[port.update_set], update_way);
	// Tree bits seen by the snoop, write-first
	assign lru_snoop = same_set ? lru_next : lru_bits[port.snoop_set];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			tags <= '{default: '0};
			states <= '{default: INVALID};
			lru_bits <= '{default: '0};
			port.snoop_tag <= '0;
			port.snoop_state <= {L1D_WAYS{INVALID}};
			port.replace_way <= '0;
		end
		else
		begin
			// Fill write
			for (int w = 0; w < L1D_WAYS; w++)
			begin
				if (port.update_en_oh[w])
				begin
					tags[port.update_set][w] <= port.update_tag;
					states[port.update_set][w] <= port.update_state;
				end
			end
			if (update_any)
				lru_bits[port.update_set] <= lru_next;

			// Snoop read of all ways, forwarding the way being written
			for (int w = 0; w < L1D_WAYS; w++)
			begin
				if (same_set && port.update_en_oh[w])
				begin
					port.snoop_tag[w] <= port.update_tag;
					port.snoop_state[w] <= port.update_state;
				end
				else
				begin
					port.snoop_tag[w] <= tags[port.snoop_set][w];
					port.snoop_state[w] <= states[port.snoop_set][w];
				end
			end
			port.replace_way <= plru_victim(lru_snoop);
		end
	end

endmodule

// ==== rtl/l1i_tag_store.sv ====
`timescale 1ns/100ps

module l1i_tag_store
	import ring_cache_pkg::*;
	(input clk,
	input reset,
	l1i_tag_port_if.store port);

	l1i_tag_t tags [L1I_SETS][L1I_WAYS];
	logic [L1I_WAYS-1:0] valid_bits [L1I_SETS];
	plru_bits_t lru_bits [L1I_SETS];

	logic update_any;
	logic same_set;
	plru_way_t update_way;
	plru_bits_t lru_next;
	plru_bits_t lru_snoop;

	assign update_any = |port.update_en_oh;
	assign same_set = update_any && port.update_set == port.snoop_set;
	assign update_way = way_from_oh(port.update_en_oh);
	assign lru_next = plru_update(lru_bits[port.update_set], update_way);
	// Back-to-back fills of one set must see the new tree
	assign lru_snoop = same_set ? lru_next : lru_bits[port.snoop_set];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			tags <= '{default: '0};
			valid_bits <= '{default: '0};
			lru_bits <= '{default: '0};
			port.replace_way <= '0;
		end
		else
		begin
			for (int w = 0; w < L1I_WAYS; w++)
			begin
				if (port.update_en_oh[w])
				begin
					tags[port.update_set][w] <= port.update_tag;
					valid_bits[port.update_set][w] <= 1'b1;
				end
			end
			if (update_any)
				lru_bits[port.update_set] <= lru_next;
			// Only the victim is needed, fills never hit here
			port.replace_way <= plru_victim(lru_snoop);
		end
	end

endmodule

// ==== rtl/rc_fill_stage.sv ====
`timescale 1ns/100ps

module rc_fill_stage
	import ring_cache_pkg::*;
	(input clk,
	input reset,

	// From stage 1
	input ring_packet_t rc1_packet,
	input thread_idx_t rc1_thread,
	input rc1_store,

	// Snoop results in, tag writes out
	l1d_tag_port_if.update dtag,
	l1i_tag_port_if.update itag,

	// Fill report
	output logic fill_valid,
	output cache_type_t fill_cache_type,
	output thread_idx_t fill_thread,
	output l1d_way_idx_t fill_way,
	output logic need_writeback,
	output logic [ADDR_W-1:0] evicted_addr,
	output logic orphan_ack);

	l1d_addr_t daddr;
	l1i_addr_t iaddr;
	logic [L1D_WAYS-1:0] hit_oh;
	logic dcache_hit;
	l1d_way_idx_t hit_way;
	l1d_way_idx_t way_sel;
	logic [L1D_WAYS-1:0] way_oh;
	logic do_fill;
	logic do_dfill;
	logic do_ifill;
	logic victim_dirty;
	logic writeback_next;

	assign daddr = rc1_packet.addr.dcache;
	assign iaddr = rc1_packet.addr.icache;

	// Only matched acknowledges fill
	assign do_fill = rc1_packet.valid && rc1_packet.ack_match;
	assign do_dfill = do_fill && rc1_packet.cache_type == CT_DCACHE;
	assign do_ifill = do_fill && rc1_packet.cache_type == CT_ICACHE;

	// Tag compare against every valid data way
	always_comb
	begin
		for (int w = 0; w < L1D_WAYS; w++)
			hit_oh[w] = dtag.snoop_tag[w] == daddr.tag && dtag.snoop_state[w] != INVALID;
	end

	assign dcache_hit = |hit_oh;
	assign hit_way = way_from_oh(hit_oh);

	// Data hit refills its own way, otherwise the tree victim
	always_comb
	begin
		if (rc1_packet.cache_type == CT_ICACHE)
			way_sel = itag.replace_way;
		else if (dcache_hit)
			way_sel = hit_way;
		else
			way_sel = dtag.replace_way;
	end

	assign way_oh = L1D_WAYS'(1) << way_sel;

	// Data tag write
	assign dtag.update_en_oh = way_oh & {L1D_WAYS{do_dfill}};
	assign dtag.update_set = daddr.set_idx;
	assign dtag.update_tag = daddr.tag;
	assign dtag.update_state = rc1_store ? MODIFIED : SHARED;

	// Instruction tag write
	assign itag.update_en_oh = way_oh & {L1I_WAYS{do_ifill}};
	assign itag.update_set = iaddr.set_idx;
	assign itag.update_tag = iaddr.tag;

	// Writeback only when a dirty victim is displaced
	assign victim_dirty = dtag.snoop_state[dtag.replace_way] == MODIFIED;
	assign writeback_next = do_dfill && !dcache_hit && victim_dirty;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			fill_valid <= 1'b0;
			need_writeback <= 1'b0;
			orphan_ack <= 1'b0;
		end
		else
		begin
			fill_valid <= do_fill;
			need_writeback <= writeback_next;
			orphan_ack <= rc1_packet.valid && !rc1_packet.ack_match;
		end
	end

	// Report payload, qualified by fill_valid
	always_ff @(posedge clk)
	begin
		fill_cache_type <= rc1_packet.cache_type;
		fill_thread <= rc1_thread;
		fill_way <= way_sel;
		evicted_addr <= {dtag.snoop_tag[dtag.replace_way], daddr.set_idx,
			{LINE_OFFSET_W{1'b0}}};
	end

endmodule

// ==== rtl/rc_miss_track_stage.sv ====
`timescale 1ns/100ps

module rc_miss_track_stage
	import ring_cache_pkg::*;
	#(parameter core_id_t CORE_ID = '0)
	(input clk,
	input reset,

	// Miss registration from the core
	input miss_valid,
	input cache_type_t miss_cache_type,
	input thread_idx_t miss_thread,
	input miss_store,
	input [ADDR_W-1:0] miss_addr,

	// Ring slot
	input ring_valid,
	input ring_ack,
	input core_id_t ring_dest_core,
	input cache_type_t ring_cache_type,
	input [ADDR_W-1:0] ring_addr,

	// Toward stage 2
	output ring_packet_t rc1_packet,
	output thread_idx_t rc1_thread,
	output logic rc1_store,

	// Snoop set requests
	l1d_tag_port_if.snoop dtag,
	l1i_tag_port_if.snoop itag);

	// Miss tables, first index is the cache type
	logic [THREADS_PER_CORE-1:0] entry_pending [2];
	logic [LINE_ADDR_W-1:0] entry_line [2][THREADS_PER_CORE];
	logic entry_store [2][THREADS_PER_CORE];

	ring_addr_u ring_word;
	logic [LINE_ADDR_W-1:0] ring_line;
	logic ack_for_me;
	logic match_hit;
	logic matched;
	thread_idx_t match_thread;

	assign ring_word = ring_addr;
	assign ring_line = ring_addr[ADDR_W-1:LINE_OFFSET_W];
	assign ack_for_me = ring_valid && ring_ack && ring_dest_core == CORE_ID;

	// Same word, two set decodes; the tag stores read every cycle
	assign dtag.snoop_set = ring_word.dcache.set_idx;
	assign itag.snoop_set = ring_word.icache.set_idx;

	// Search downward so the lowest matching thread is the last written
	always_comb
	begin
		match_hit = 1'b0;
		match_thread = '0;
		for (int t = THREADS_PER_CORE - 1; t >= 0; t--)
		begin
			if (entry_pending[ring_cache_type][t]
				&& entry_line[ring_cache_type][t] == ring_line)
			begin
				match_hit = 1'b1;
				match_thread = thread_idx_t'(t);
			end
		end
	end

	assign matched = ack_for_me && match_hit;

	// Pending bits
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			entry_pending <= '{default: '0};
		else
		begin
			if (matched)
				entry_pending[ring_cache_type][match_thread] <= 1'b0;
			// A registration in the same cycle wins over the clear
			if (miss_valid)
				entry_pending[miss_cache_type][miss_thread] <= 1'b1;
		end
	end

	// Line address and load/store kind of each entry
	always_ff @(posedge clk)
	begin
		if (miss_valid)
		begin
			entry_line[miss_cache_type][miss_thread] <= miss_addr[ADDR_W-1:LINE_OFFSET_W];
			entry_store[miss_cache_type][miss_thread] <= miss_store;
		end
	end

	// Packet register, valid marks any acknowledge sent to this core
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			rc1_packet <= '0;
		else
		begin
			rc1_packet.valid <= ack_for_me;
			rc1_packet.cache_type <= ring_cache_type;
			rc1_packet.addr <= ring_word;
			rc1_packet.ack_match <= matched;
		end
	end

	always_ff @(posedge clk)
	begin
		rc1_thread <= match_thread;
		rc1_store <= entry_store[ring_cache_type][match_thread];
	end

endmodule

// ==== rtl/ring_cache_ctrl.sv ====
`timescale 1ns/100ps

module ring_cache_ctrl
	import ring_cache_pkg::*;
	#(parameter core_id_t CORE_ID = '0)
	(input clk,
	input reset,

	// Miss registration
	input miss_valid,
	input cache_type_t miss_cache_type,
	input thread_idx_t miss_thread,
	input miss_store,
	input [ADDR_W-1:0] miss_addr,

	// Ring slot
	input ring_valid,
	input ring_ack,
	input core_id_t ring_dest_core,
	input cache_type_t ring_cache_type,
	input [ADDR_W-1:0] ring_addr,

	// Fill report
	output logic fill_valid,
	output cache_type_t fill_cache_type,
	output thread_idx_t fill_thread,
	output l1d_way_idx_t fill_way,
	output logic need_writeback,
	output logic [ADDR_W-1:0] evicted_addr,
	output logic orphan_ack);

	ring_packet_t rc1_packet;
	thread_idx_t rc1_thread;
	logic rc1_store;

	l1d_tag_port_if dtag_port();
	l1i_tag_port_if itag_port();

	// Stage 1, miss tables and acknowledge match
	rc_miss_track_stage #(.CORE_ID(CORE_ID)) i_miss_track (
		.clk(clk),
		.reset(reset),
		.miss_valid(miss_valid),
		.miss_cache_type(miss_cache_type),
		.miss_thread(miss_thread),
		.miss_store(miss_store),
		.miss_addr(miss_addr),
		.ring_valid(ring_valid),
		.ring_ack(ring_ack),
		.ring_dest_core(ring_dest_core),
		.ring_cache_type(ring_cache_type),
		.ring_addr(ring_addr),
		.rc1_packet(rc1_packet),
		.rc1_thread(rc1_thread),
		.rc1_store(rc1_store),
		.dtag(dtag_port.snoop),
		.itag(itag_port.snoop));

	// Tag stores snoop alongside stage 1
	l1d_tag_store i_l1d_tags (
		.clk(clk),
		.reset(reset),
		.port(dtag_port.store));

	l1i_tag_store i_l1i_tags (
		.clk(clk),
		.reset(reset),
		.port(itag_port.store));

	// Stage 2, fill decision and report
	rc_fill_stage i_fill (
		.clk(clk),
		.reset(reset),
		.rc1_packet(rc1_packet),
		.rc1_thread(rc1_thread),
		.rc1_store(rc1_store),
		.dtag(dtag_port.update),
		.itag(itag_port.update),
		.fill_valid(fill_valid),
		.fill_cache_type(fill_cache_type),
		.fill_thread(fill_thread),
		.fill_way(fill_way),
		.need_writeback(need_writeback),
		.evicted_addr(evicted_addr),
		.orphan_ack(orphan_ack));

endmodule

// ==== rtl/ring_cache_pkg.sv ====
package ring_cache_pkg;

	// Core and cache geometry
	localparam THREADS_PER_CORE = 4;
	localparam L1D_WAYS = 4;
	localparam L1I_WAYS = 4;
	localparam L1D_SETS = 64;
	localparam L1I_SETS = 32;
	localparam LINE_OFFSET_W = 6;
	localparam CORE_ID_W = 2;
	localparam ADDR_W = 32;

	// Address field widths
	localparam L1D_SET_W = $clog2(L1D_SETS);
	localparam L1I_SET_W = $clog2(L1I_SETS);
	localparam L1D_TAG_W = ADDR_W - L1D_SET_W - LINE_OFFSET_W;
	localparam L1I_TAG_W = ADDR_W - L1I_SET_W - LINE_OFFSET_W;
	// Line address, offset stripped
	localparam LINE_ADDR_W = ADDR_W - LINE_OFFSET_W;

	typedef logic [$clog2(THREADS_PER_CORE)-1:0] thread_idx_t;
	typedef logic [CORE_ID_W-1:0] core_id_t;
	typedef logic [$clog2(L1D_WAYS)-1:0] l1d_way_idx_t;
	typedef logic [$clog2(L1I_WAYS)-1:0] l1i_way_idx_t;
	typedef logic [L1D_SET_W-1:0] l1d_set_idx_t;
	typedef logic [L1I_SET_W-1:0] l1i_set_idx_t;
	typedef logic [L1D_TAG_W-1:0] l1d_tag_t;
	typedef logic [L1I_TAG_W-1:0] l1i_tag_t;

	// Tree pseudo-LRU for four ways, bit 2 root, bit 1 left, bit 0 right
	typedef logic [2:0] plru_bits_t;
	typedef logic [1:0] plru_way_t;

	typedef struct packed {
		l1d_tag_t tag;
		l1d_set_idx_t set_idx;
		logic [LINE_OFFSET_W-1:0] offset;
	} l1d_addr_t;

	typedef struct packed {
		l1i_tag_t tag;
		l1i_set_idx_t set_idx;
		logic [LINE_OFFSET_W-1:0] offset;
	} l1i_addr_t;

	// One ring address word, split by whichever cache it targets
	typedef union packed {
		l1d_addr_t dcache;
		l1i_addr_t icache;
	} ring_addr_u;

	typedef enum logic {
		CT_DCACHE,
		CT_ICACHE
	} cache_type_t;

	typedef enum logic [1:0] {
		INVALID,
		SHARED,
		MODIFIED
	} line_state_t;

	// Stage 1 register toward the fill stage
	typedef struct packed {
		logic valid;
		cache_type_t cache_type;
		ring_addr_u addr;
		logic ack_match;
	} ring_packet_t;

	// Victim: left subtree on root 0, right subtree on root 1
	function automatic plru_way_t plru_victim(input plru_bits_t bits);
		return bits[2] ? {1'b1, bits[0]} : {1'b0, bits[1]};
	endfunction

	// Turn the tree away from the way just filled
	function automatic plru_bits_t plru_update(input plru_bits_t bits, input plru_way_t way);
		plru_bits_t next;
		next = bits;
		next[2] = ~way[1];
		if (way[1])
			next[0] = ~way[0];
		else
			next[1] = ~way[0];
		return next;
	endfunction

	// Lowest set bit wins
	function automatic plru_way_t way_from_oh(input logic [3:0] oh);
		plru_way_t idx;
		idx = '0;
		for (int i = 3; i >= 0; i--)
			if (oh[i])
				idx = plru_way_t'(i);
		return idx;
	endfunction

endpackage

// ==== rtl/tag_port_if.sv ====
`timescale 1ns/100ps

// Data cache tag port, snoop read plus one-hot fill write
interface l1d_tag_port_if
	import ring_cache_pkg::*;
	();

	// Snoop set comes straight from the ring input
	l1d_set_idx_t snoop_set;
	// Registered snoop results, one per way
	line_state_t [L1D_WAYS-1:0] snoop_state;
	l1d_tag_t [L1D_WAYS-1:0] snoop_tag;
	l1d_way_idx_t replace_way;

	// Fill write from stage 2
	logic [L1D_WAYS-1:0] update_en_oh;
	l1d_set_idx_t update_set;
	l1d_tag_t update_tag;
	line_state_t update_state;

	modport snoop(output snoop_set);

	modport store(input snoop_set, update_en_oh, update_set, update_tag, update_state,
		output snoop_state, snoop_tag, replace_way);

	modport update(input snoop_state, snoop_tag, replace_way,
		output update_en_oh, update_set, update_tag, update_state);

endinterface

// Instruction cache tag port, only the victim way comes back
interface l1i_tag_port_if
	import ring_cache_pkg::*;
	();

	l1i_set_idx_t snoop_set;
	l1i_way_idx_t replace_way;

	// Any write marks the way valid
	logic [L1I_WAYS-1:0] update_en_oh;
	l1i_set_idx_t update_set;
	l1i_tag_t update_tag;

	modport snoop(output snoop_set);

	modport store(input snoop_set, update_en_oh, update_set, update_tag,
		output replace_way);

	modport update(input replace_way,
		output update_en_oh, update_set, update_tag);

endinterface

// ==== tb.f ====
rtl/ring_cache_pkg.sv
rtl/tag_port_if.sv
rtl/rc_miss_track_stage.sv
rtl/l1d_tag_store.sv
rtl/l1i_tag_store.sv
rtl/rc_fill_stage.sv
rtl/ring_cache_ctrl.sv
bench/rc_checker.sv
bench/tb_ring_cache_ctrl.sv
